// File: run_sim.sh
#!/bin/sh
# build and run the bignum multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module bignum_multiplier_tb \
    -f vlog.f -o sim_bignum
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_bignum)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1

// File: src/bignum_multiplier_top.sv
`timescale 1ns/1ps

module bignum_multiplier_top import bignum_pkg::*; #(
    parameter int NUM_BITS = 128,
    localparam int D = NUM_BITS / WORD_BITS,
    localparam int AW = $clog2(D)
) (
    input  logic  clk_in,
    input  logic  rst_in,
    input  word_t n_in,
    input  word_t m_in,
    input  logic  valid_in,
    output word_t data_out,
    output logic  valid_out,
    output logic  final_out,
    output logic  ready_out
);

    logic          wr_en;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr_n;
    logic [AW-1:0] rd_addr_m;
    logic [AW-1:0] row_base;
    logic          row_go;
    logic          row_first;
    logic          row_flush;
    logic          clear;
    logic          drain_start;
    logic          out_done;
    word_t         n_word;
    word_t         m_word;
    row_word_t     row_word;

    mult_control #(.NUM_BITS(NUM_BITS)) u_control (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .out_done    (out_done),
        .ready_out   (ready_out),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .rd_addr_n   (rd_addr_n),
        .rd_addr_m   (rd_addr_m),
        .row_go      (row_go),
        .row_first   (row_first),
        .row_flush   (row_flush),
        .clear       (clear),
        .row_base    (row_base),
        .drain_start (drain_start)
    );

    operand_store #(.NUM_BITS(NUM_BITS)) u_store (
        .clk_in    (clk_in),
        .n_in      (n_in),
        .m_in      (m_in),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .rd_addr_n (rd_addr_n),
        .rd_addr_m (rd_addr_m),
        .n_word    (n_word),
        .m_word    (m_word)
    );

    row_builder u_row (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .n_word    (n_word),
        .m_word    (m_word),
        .row_go    (row_go),
        .row_first (row_first),
        .row_flush (row_flush),
        .row_out   (row_word)
    );

    product_accumulator #(.NUM_BITS(NUM_BITS)) u_accum (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .clear       (clear),
        .row_in      (row_word),
        .row_base    (row_base),
        .drain_start (drain_start),
        .data_out    (data_out),
        .valid_out   (valid_out),
        .final_out   (final_out),
        .out_done    (out_done)
    );

endmodule

// File: src/bignum_pkg.sv
package bignum_pkg;

    parameter int WORD_BITS = 32;

    // one word of an operand or of the product
    typedef logic [WORD_BITS-1:0] word_t;

    // full product of two words
    typedef logic [2*WORD_BITS-1:0] chunk_t;

    // one word of a partial-product row
    typedef struct packed {
        word_t data;
        logic  valid;
        logic  first;
    } row_word_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ROW_START,
        ROW_STREAM,
        ROW_FLUSH,
        OUTPUT
    } mult_state_t;

endpackage

// File: src/mult_control.sv
`timescale 1ns/1ps

module mult_control import bignum_pkg::*; #(
    parameter int NUM_BITS = 128,
    localparam int D = NUM_BITS / WORD_BITS,
    localparam int AW = $clog2(D)
) (
    input  logic          clk_in,
    input  logic          rst_in,
    input  logic          valid_in,
    input  logic          out_done,
    output logic          ready_out,
    output logic          wr_en,
    output logic [AW-1:0] wr_addr,
    output logic [AW-1:0] rd_addr_n,
    output logic [AW-1:0] rd_addr_m,
    output logic          row_go,
    output logic          row_first,
    output logic          row_flush,
    output logic          clear,
    output logic [AW-1:0] row_base,
    output logic          drain_start
);

    mult_state_t   state;
    logic [AW:0]   word_cnt;
    logic [AW-1:0] row_cnt;
    logic          settle;
    logic          last_row;

    assign last_row  = row_cnt == AW'(D - 1);
    assign ready_out = state == IDLE;

    // loading uses word_cnt as the write address
    assign wr_en   = valid_in && (state == IDLE || state == LOAD);
    assign wr_addr = word_cnt[AW-1:0];
    assign clear   = state == IDLE && valid_in;

    // during a row word_cnt runs one ahead of the n word at the row builder
    assign rd_addr_n = word_cnt[AW-1:0];
    assign rd_addr_m = row_cnt;
    assign row_base  = row_cnt;
    assign row_go    = state == ROW_STREAM;
    assign row_first = state == ROW_STREAM && word_cnt == (AW + 1)'(1);
    assign row_flush = state == ROW_FLUSH && !settle;

    assign drain_start = state == ROW_FLUSH && settle && last_row;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= IDLE;
            word_cnt <= '0;
            row_cnt  <= '0;
            settle   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // word 0 is stored on this strobe
                    if (valid_in) begin
                        word_cnt <= (AW + 1)'(1);
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    if (valid_in) begin
                        if (word_cnt == (AW + 1)'(D - 1)) begin
                            word_cnt <= '0;
                            state    <= ROW_START;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                ROW_START: begin
                    // address 0 goes out here, n word 0 is back next cycle
                    word_cnt <= (AW + 1)'(1);
                    state    <= ROW_STREAM;
                end
                ROW_STREAM: begin
                    if (word_cnt == (AW + 1)'(D)) begin
                        word_cnt <= '0;
                        state    <= ROW_FLUSH;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                ROW_FLUSH: begin
                    // flush cycle, then one cycle for the last row word to land
                    settle <= !settle;
                    if (settle) begin
                        if (last_row) begin
                            state <= OUTPUT;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                            state   <= ROW_START;
                        end
                    end
                end
                OUTPUT: begin
                    if (out_done) begin
                        row_cnt <= '0;
                        state   <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/operand_store.sv
`timescale 1ns/1ps

module operand_store import bignum_pkg::*; #(
    parameter int NUM_BITS = 128,
    localparam int D = NUM_BITS / WORD_BITS,
    localparam int AW = $clog2(D)
) (
    input  logic          clk_in,
    input  word_t         n_in,
    input  word_t         m_in,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  logic [AW-1:0] rd_addr_n,
    input  logic [AW-1:0] rd_addr_m,
    output word_t         n_word,
    output word_t         m_word
);

    word_t n_mem [D];
    word_t m_mem [D];

    // n and m arrive side by side, so one write port serves both
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            n_mem[wr_addr] <= n_in;
            m_mem[wr_addr] <= m_in;
        end
    end

    // read data lags the address by one cycle, like a block RAM
    always_ff @(posedge clk_in) begin
        n_word <= n_mem[rd_addr_n];
        m_word <= m_mem[rd_addr_m];
    end

endmodule

// File: src/product_accumulator.sv
`timescale 1ns/1ps

module product_accumulator import bignum_pkg::*; #(
    parameter int NUM_BITS = 128,
    localparam int D = NUM_BITS / WORD_BITS,
    localparam int AW = $clog2(D),
    localparam int PD = 2 * D,
    localparam int PAW = $clog2(PD)
) (
    input  logic          clk_in,
    input  logic          rst_in,
    input  logic          clear,
    input  row_word_t     row_in,
    input  logic [AW-1:0] row_base,
    input  logic          drain_start,
    output word_t         data_out,
    output logic          valid_out,
    output logic          final_out,
    output logic          out_done
);

    word_t              acc [PD];
    logic [PAW-1:0]     row_idx;
    logic [PAW-1:0]     wr_ptr;
    logic               carry;
    logic [WORD_BITS:0] sum;
    logic               draining;
    logic [PAW-1:0]     rd_ptr;

    // row word k lands at entry row_base + k
    assign wr_ptr = PAW'(row_base) + (row_in.first ? PAW'(0) : row_idx);

    assign sum = {1'b0, acc[wr_ptr]}
               + {1'b0, row_in.data}
               + (WORD_BITS + 1)'(row_in.first ? 1'b0 : carry);

    always_ff @(posedge clk_in) begin
        if (clear) begin
            for (int k = 0; k < PD; k++) begin
                acc[k] <= '0;
            end
        end else if (row_in.valid) begin
            acc[wr_ptr] <= sum[WORD_BITS-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (draining) begin
            data_out <= acc[rd_ptr];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            carry     <= 1'b0;
            row_idx   <= '0;
            draining  <= 1'b0;
            rd_ptr    <= '0;
            valid_out <= 1'b0;
            final_out <= 1'b0;
        end else begin
            if (row_in.valid) begin
                carry   <= sum[WORD_BITS];
                row_idx <= row_in.first ? PAW'(1) : row_idx + 1'b1;
            end

            valid_out <= draining;
            final_out <= draining && rd_ptr == PAW'(PD - 1);

            // stream entries 0 .. 2D-1 on consecutive cycles
            if (drain_start) begin
                draining <= 1'b1;
                rd_ptr   <= '0;
            end else if (draining) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (rd_ptr == PAW'(PD - 1)) begin
                    draining <= 1'b0;
                end
            end
        end
    end

    assign out_done = final_out;

endmodule

// File: src/row_builder.sv
`timescale 1ns/1ps

module row_builder import bignum_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  word_t     n_word,
    input  word_t     m_word,
    input  logic      row_go,
    input  logic      row_first,
    input  logic      row_flush,
    output row_word_t row_out
);

    chunk_t             chunk;
    word_t              hi_prev;
    logic               carry;
    word_t              hi_base;
    logic               carry_base;
    logic [WORD_BITS:0] fold;

    assign chunk = n_word * m_word;

    // a new row starts without a saved high half or carry
    assign hi_base    = row_first ? '0 : hi_prev;
    assign carry_base = row_first ? 1'b0 : carry;

    // low half of this chunk plus high half of the one before
    assign fold = {1'b0, chunk[WORD_BITS-1:0]}
                + {1'b0, hi_base}
                + (WORD_BITS + 1)'(carry_base);

    always_ff @(posedge clk_in) begin
        if (row_go) begin
            row_out.data <= fold[WORD_BITS-1:0];
            hi_prev      <= chunk[2*WORD_BITS-1:WORD_BITS];
        end else if (row_flush) begin
            // top word of the row, cannot overflow
            row_out.data <= hi_prev + word_t'(carry);
        end

        if (rst_in) begin
            row_out.valid <= 1'b0;
            row_out.first <= 1'b0;
            carry         <= 1'b0;
        end else begin
            row_out.valid <= row_go || row_flush;
            row_out.first <= row_go && row_first;
            if (row_go) begin
                carry <= fold[WORD_BITS];
            end
        end
    end

endmodule

// File: verification/bignum_multiplier_tb.sv
`timescale 1ns/1ps

module bignum_multiplier_tb import bignum_pkg::*; ();

    localparam int NUM_BITS = 128;
    localparam int D = NUM_BITS / WORD_BITS;
    localparam int PD = 2 * D;
    // far above the few hundred cycles the whole run needs
    localparam int MAX_CYCLES = 20000;

    typedef logic [NUM_BITS-1:0]   operand_t;
    typedef logic [2*NUM_BITS-1:0] product_t;

    logic   clk_in;
    logic   rst_in;
    word_t  n_in;
    word_t  m_in;
    logic   valid_in;
    word_t  data_out;
    logic   valid_out;
    logic   final_out;
    logic   ready_out;

    int     cycle_count = 0;
    int     error_count = 0;
    int     checks_done = 0;
    int     test_count = 0;
    int     errors_before;
    int     valid_seen = 0;
    int     final_seen = 0;
    integer seed = 32'h86609bfb;
    string  test_name;

    bignum_multiplier_top #(.NUM_BITS(NUM_BITS)) UUT (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .n_in      (n_in),
        .m_in      (m_in),
        .valid_in  (valid_in),
        .data_out  (data_out),
        .valid_out (valid_out),
        .final_out (final_out),
        .ready_out (ready_out)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: no result after %0d cycles in test %s", cycle_count, test_name);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // every wait goes through here, so output strobes are counted on each edge
    task automatic next_cycle();
        @(posedge clk_in);
        if (valid_out === 1'b1) begin
            valid_seen++;
        end
        if (final_out === 1'b1) begin
            final_seen++;
        end
    endtask

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s %s: expected %08h, actual %08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic check_number(input string what, input int expected, input int actual);
        checks_done++;
        if (actual != expected) begin
            error_count++;
            $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_before = error_count;
        test_count++;
    endtask

    task automatic end_test();
        if (error_count == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, error_count - errors_before);
        end
    endtask

    task automatic wait_ready();
        do begin
            next_cycle();
        end while (ready_out !== 1'b1);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            next_cycle();
            valid_in <= 1'b0;
        end
    endtask

    task automatic random_operand(output operand_t value);
        for (int k = 0; k < D; k++) begin
            value[k*WORD_BITS +: WORD_BITS] = $random(seed);
        end
    endtask

    // least significant word first, optional random gaps between strobes
    task automatic load_operands(input operand_t n, input operand_t m, input int max_gap);
        int gap;
        for (int k = 0; k < D; k++) begin
            gap = 0;
            if (max_gap > 0 && k > 0) begin
                gap = int'($unsigned($random(seed)) % (max_gap + 1));
            end
            idle_cycles(gap);
            next_cycle();
            n_in     <= n[k*WORD_BITS +: WORD_BITS];
            m_in     <= m[k*WORD_BITS +: WORD_BITS];
            valid_in <= 1'b1;
        end
        idle_cycles(1);
    endtask

    task automatic collect_product(output product_t product);
        word_t words [$];
        product = '0;
        do begin
            next_cycle();
            check_flag("ready_out while busy", 1'b0, ready_out);
            if (valid_out === 1'b1) begin
                words.push_back(data_out);
            end
            if (final_out === 1'b1) begin
                check_flag("valid_out with final_out", 1'b1, valid_out);
            end
        end while (final_out !== 1'b1);
        check_number("words before final_out", PD, words.size());
        for (int k = 0; k < words.size() && k < PD; k++) begin
            product[k*WORD_BITS +: WORD_BITS] = words[k];
        end
    endtask

    task automatic run_product(input operand_t n, input operand_t m, input int max_gap);
        product_t expected;
        product_t actual;
        expected = product_t'(n) * product_t'(m);
        load_operands(n, m, max_gap);
        collect_product(actual);
        for (int k = 0; k < PD; k++) begin
            check_word($sformatf("word %0d", k), expected[k*WORD_BITS +: WORD_BITS],
                       actual[k*WORD_BITS +: WORD_BITS]);
        end
    endtask

    task automatic test_small_product();
        begin_test("small_product");
        wait_ready();
        run_product(operand_t'(3), operand_t'(5), 0);
        end_test();
    endtask

    task automatic test_all_ones();
        begin_test("all_ones");
        wait_ready();
        run_product('1, '1, 0);
        end_test();
    endtask

    task automatic test_zero_operand();
        operand_t n;
        begin_test("zero_operand");
        random_operand(n);
        wait_ready();
        run_product(n, '0, 0);
        end_test();
    endtask

    task automatic test_random_products();
        operand_t n;
        operand_t m;
        begin_test("random_products");
        repeat (5) begin
            random_operand(n);
            random_operand(m);
            wait_ready();
            run_product(n, m, 3);
        end
        end_test();
    endtask

    task automatic test_back_to_back();
        int       valid_start;
        int       final_start;
        operand_t m_first;
        begin_test("back_to_back");
        m_first = operand_t'(128'h12345678_9abcdef0_0fedcba9_87654321);
        wait_ready();
        valid_start = valid_seen;
        final_start = final_seen;
        // large first product leaves every accumulator word nonzero
        run_product('1, m_first, 0);
        run_product(operand_t'(7), operand_t'(9), 0);
        idle_cycles(PD + 4);
        check_number("valid_out cycles", 2 * PD, valid_seen - valid_start);
        check_number("final_out cycles", 2, final_seen - final_start);
        end_test();
    endtask

    initial begin
        clk_in   = 1'b0;
        rst_in   = 1'b1;
        n_in     = '0;
        m_in     = '0;
        valid_in = 1'b0;
        test_name = "reset";
        repeat (8) begin
            next_cycle();
        end
        rst_in <= 1'b0;

        test_small_product();
        test_all_ones();
        test_zero_operand();
        test_random_products();
        test_back_to_back();

        $display("%0d tests, %0d checks, %0d errors", test_count, checks_done, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/bignum_pkg.sv
src/operand_store.sv
src/row_builder.sv
src/product_accumulator.sv
src/mult_control.sv
src/bignum_multiplier_top.sv
verification/bignum_multiplier_tb.sv
